// File: common/mbox_pkg.sv
// mailbox shared definitions
// data and address widths, host address map, AXI response codes
// and the memory message type codes used on the val/rdy request path
package mbox_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  // one host word per RAM word
  localparam int MBOX_DATA_W = 32;
  // host byte address
  localparam int MBOX_ADDR_W = 32;

  // ----------------------------------------
  // host address map
  // ----------------------------------------
  // memory window starts here and spans 2^RAM_AW words
  localparam logic [MBOX_ADDR_W-1:0] RAM_BASE_ADDR = 32'h0000_1000;
  // read-only identification register
  localparam logic [MBOX_ADDR_W-1:0] ID_REG_ADDR   = 32'h0000_0000;
  localparam logic [MBOX_DATA_W-1:0] MBOX_ID       = 32'h4d42_0001;

  // ----------------------------------------
  // memory message types
  // ----------------------------------------
  localparam int MEM_TYPE_W = 3;
  localparam logic [MEM_TYPE_W-1:0] MEM_TYPE_READ  = 3'd0;
  localparam logic [MEM_TYPE_W-1:0] MEM_TYPE_WRITE = 3'd1;

  // response message is {type, data}
  localparam int RESP_MSG_W = MEM_TYPE_W + MBOX_DATA_W;

  // ----------------------------------------
  // AXI response codes
  // ----------------------------------------
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: bram/bypass_queue_stage.sv
// single-element bypass queue stage
// empty stage passes input straight through, message is stored
// only when the downstream side does not take it
`timescale 1ns/1ps

module bypass_queue_stage #(
  parameter int MSG_W = 32
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic [MSG_W-1:0] enq_msg,
  input  logic             enq_val,
  output logic             enq_rdy,
  output logic [MSG_W-1:0] deq_msg,
  output logic             deq_val,
  input  logic             deq_rdy,
  output logic             full
);

  logic [MSG_W-1:0] msg_q;
  logic             do_enq;
  logic             do_deq;

  // storage free means ready
  assign enq_rdy = ~full;
  assign deq_val = full | enq_val;
  // stored entry goes out ahead of the bypass
  assign deq_msg = full ? msg_q : enq_msg;

  assign do_enq = enq_val & enq_rdy;
  assign do_deq = deq_val & deq_rdy;

  // dequeue empties the stage and an unbypassed enqueue fills it
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      full <= 1'b0;
    end else if (do_deq) begin
      full <= 1'b0;
    end else if (do_enq) begin
      full <= 1'b1;
    end
  end

  // capture on every enqueue and keep it only if full rises
  always_ff @(posedge clk_main_a0) begin
    if (do_enq) begin
      msg_q <= enq_msg;
    end
  end

endmodule

// File: bram/bram_port.sv
// block RAM port with val/rdy request and response
// request stage writes or reads the RAM array, response stage
// builds {type, data} and offers it to the bypass queue chain
`timescale 1ns/1ps

module bram_port
  import mbox_pkg::*;
#(
  parameter int RAM_AW          = 8,
  parameter int NUM_RESP_STAGES = 2
) (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  logic                       mem_req_val,
  output logic                       mem_req_rdy,
  input  logic [MEM_TYPE_W-1:0]      mem_req_type,
  input  logic [RAM_AW-1:0]          mem_req_addr,
  input  logic [MBOX_DATA_W-1:0]     mem_req_data,
  input  logic [NUM_RESP_STAGES-1:0] stage_full,
  output logic [RESP_MSG_W-1:0]      enq_msg,
  output logic                       enq_val,
  input  logic                       enq_rdy
);

  // 2^RAM_AW words with synchronous read
  logic [MBOX_DATA_W-1:0] ram [2**RAM_AW];
  logic [MBOX_DATA_W-1:0] ram_rdata;

  logic                  req_go;
  logic                  req_wen;
  logic                  resp_val_q;
  logic [MEM_TYPE_W-1:0] resp_type_q;
  logic [MBOX_DATA_W-1:0] resp_data;

  // ----------------------------------------
  // request stage
  // ----------------------------------------
  // take a request only with the whole response path empty
  assign mem_req_rdy = ~resp_val_q & ~(|stage_full);
  assign req_go      = mem_req_val & mem_req_rdy;
  assign req_wen     = req_go & (mem_req_type == MEM_TYPE_WRITE);

  // write or read at the edge ending the accept cycle
  always_ff @(posedge clk_main_a0) begin
    if (req_wen) begin
      ram[mem_req_addr] <= mem_req_data;
    end else if (req_go) begin
      ram_rdata <= ram[mem_req_addr];
    end
  end

  // ----------------------------------------
  // response stage
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      resp_val_q <= 1'b0;
    end else if (req_go) begin
      resp_val_q <= 1'b1;
    end else if (enq_val && enq_rdy) begin
      resp_val_q <= 1'b0;
    end
  end

  // type travels with the response
  always_ff @(posedge clk_main_a0) begin
    if (req_go) begin
      resp_type_q <= mem_req_type;
    end
  end

  // write responses carry no data
  assign resp_data = (resp_type_q == MEM_TYPE_READ) ? ram_rdata : '0;

  assign enq_msg = {resp_type_q, resp_data};
  assign enq_val = resp_val_q;

endmodule

// File: host_if/axil_mbox_slave.sv
// AXI-Lite single-beat slave for the mailbox
// decodes host addresses into window, ID register or unmapped,
// issues val/rdy memory requests for window accesses, returns
// memory responses on b or r and answers ID and unmapped accesses locally
`timescale 1ns/1ps

module axil_mbox_slave
  import mbox_pkg::*;
#(
  parameter int RAM_AW = 8
) (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  input  logic [MBOX_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [MBOX_DATA_W-1:0] wdata,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [MBOX_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [MBOX_DATA_W-1:0] rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  output logic [MEM_TYPE_W-1:0]  mem_req_type,
  output logic [RAM_AW-1:0]      mem_req_addr,
  output logic [MBOX_DATA_W-1:0] mem_req_data,
  input  logic [RESP_MSG_W-1:0]  resp_msg,
  input  logic                   resp_val,
  output logic                   resp_rdy
);

  // decode results
  localparam logic [1:0] DEC_RAM  = 2'd0;
  localparam logic [1:0] DEC_ID   = 2'd1;
  localparam logic [1:0] DEC_NONE = 2'd2;

  // window covers 2^RAM_AW words from RAM_BASE_ADDR
  // byte offset bits ignored
  function automatic logic [1:0] addr_decode(input logic [MBOX_ADDR_W-1:0] addr);
    logic [MBOX_ADDR_W-1:0] offset;
    offset = addr - RAM_BASE_ADDR;
    if (addr >= RAM_BASE_ADDR && (offset >> (RAM_AW + 2)) == '0) begin
      addr_decode = DEC_RAM;
    end else if (addr == ID_REG_ADDR) begin
      addr_decode = DEC_ID;
    end else begin
      addr_decode = DEC_NONE;
    end
  endfunction

  logic                   wr_active;
  logic                   wr_data_done;
  logic [MBOX_ADDR_W-1:0] wr_addr;
  logic                   rd_active;
  logic [1:0]             wr_dec;
  logic [1:0]             rd_dec;
  logic                   aw_go, w_go, b_go, ar_go, r_go, resp_go;
  logic                   b_set, r_set;
  logic [MEM_TYPE_W-1:0]  resp_type;
  logic [MBOX_DATA_W-1:0] resp_data;
  logic                   resp_is_wr;

  // ----------------------------------------
  // handshakes
  // ----------------------------------------
  // one transaction at a time
  // write wins a tie with a read
  assign awready = ~wr_active & ~rd_active;
  assign wready  = wr_active & ~wr_data_done & wvalid;
  assign arready = ~rd_active & ~rvalid & ~wr_active & ~awvalid;
  // no new response while one is waiting on the host
  assign resp_rdy = ~bvalid & ~rvalid;

  assign aw_go   = awvalid & awready;
  assign w_go    = wready;
  assign b_go    = bvalid & bready;
  assign ar_go   = arvalid & arready;
  assign r_go    = rvalid & rready;
  assign resp_go = resp_val & resp_rdy;

  // response message fields
  assign resp_type  = resp_msg[RESP_MSG_W-1 -: MEM_TYPE_W];
  assign resp_data  = resp_msg[MBOX_DATA_W-1:0];
  assign resp_is_wr = (resp_type == MEM_TYPE_WRITE);

  assign wr_dec = addr_decode(wr_addr);
  assign rd_dec = addr_decode(araddr);

  // local answers one cycle after acceptance
  // memory answers on resp_go
  assign b_set = (w_go && wr_dec != DEC_RAM) || (resp_go && resp_is_wr);
  assign r_set = (ar_go && rd_dec != DEC_RAM) || (resp_go && !resp_is_wr);

  // ----------------------------------------
  // control state
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active    <= 1'b0;
      wr_data_done <= 1'b0;
      rd_active    <= 1'b0;
      bvalid       <= 1'b0;
      rvalid       <= 1'b0;
      mem_req_val  <= 1'b0;
    end else begin
      if (aw_go) begin
        wr_active    <= 1'b1;
        wr_data_done <= 1'b0;
      end
      if (w_go) begin
        wr_data_done <= 1'b1;
      end
      if (b_go) begin
        wr_active <= 1'b0;
      end
      if (ar_go) begin
        rd_active <= 1'b1;
      end
      if (r_go) begin
        rd_active <= 1'b0;
      end
      // response valids hold until host takes them
      if (b_go) begin
        bvalid <= 1'b0;
      end
      if (b_set) begin
        bvalid <= 1'b1;
      end
      if (r_go) begin
        rvalid <= 1'b0;
      end
      if (r_set) begin
        rvalid <= 1'b1;
      end
      // one request per window access
      if (mem_req_val && mem_req_rdy) begin
        mem_req_val <= 1'b0;
      end
      if ((w_go && wr_dec == DEC_RAM) || (ar_go && rd_dec == DEC_RAM)) begin
        mem_req_val <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // payload registers
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (aw_go) begin
      wr_addr <= awaddr;
    end
    // ID writes and unmapped writes both fail
    if (b_set) begin
      bresp <= resp_go ? RESP_OKAY : RESP_SLVERR;
    end
    if (r_set) begin
      if (resp_go) begin
        rdata <= resp_data;
        rresp <= RESP_OKAY;
      end else if (rd_dec == DEC_ID) begin
        rdata <= MBOX_ID;
        rresp <= RESP_OKAY;
      end else begin
        rdata <= '0;
        rresp <= RESP_SLVERR;
      end
    end
    // request fields held stable while mem_req_val is up
    if (w_go) begin
      mem_req_type <= MEM_TYPE_WRITE;
      mem_req_addr <= wr_addr[RAM_AW+1:2];
      mem_req_data <= wdata;
    end else if (ar_go) begin
      mem_req_type <= MEM_TYPE_READ;
      mem_req_addr <= araddr[RAM_AW+1:2];
      mem_req_data <= '0;
    end
  end

endmodule

// File: hdl/mbox_top.sv
// mailbox top level
// host AXI-Lite slave, block RAM port and a chain of single-element
// bypass queues carrying responses back to the slave
`timescale 1ns/1ps

module mbox_top
  import mbox_pkg::*;
#(
  parameter int RAM_AW          = 8,
  parameter int NUM_RESP_STAGES = 2
) (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  // write address / data / response
  input  logic [MBOX_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [MBOX_DATA_W-1:0] wdata,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  // read address / data
  input  logic [MBOX_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [MBOX_DATA_W-1:0] rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready
);

  // request path from slave to RAM port
  logic                   mem_req_val;
  logic                   mem_req_rdy;
  logic [MEM_TYPE_W-1:0]  mem_req_type;
  logic [RAM_AW-1:0]      mem_req_addr;
  logic [MBOX_DATA_W-1:0] mem_req_data;

  // response chain runs from the RAM port at index 0 to the slave at the last index
  logic [RESP_MSG_W-1:0]      chain_msg [NUM_RESP_STAGES+1];
  logic [NUM_RESP_STAGES:0]   chain_val;
  logic [NUM_RESP_STAGES:0]   chain_rdy;
  logic [NUM_RESP_STAGES-1:0] stage_full;

  axil_mbox_slave #(
    .RAM_AW (RAM_AW)
  ) u_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awaddr          (awaddr),
    .awvalid         (awvalid),
    .awready         (awready),
    .wdata           (wdata),
    .wvalid          (wvalid),
    .wready          (wready),
    .bresp           (bresp),
    .bvalid          (bvalid),
    .bready          (bready),
    .araddr          (araddr),
    .arvalid         (arvalid),
    .arready         (arready),
    .rdata           (rdata),
    .rresp           (rresp),
    .rvalid          (rvalid),
    .rready          (rready),
    .mem_req_val     (mem_req_val),
    .mem_req_rdy     (mem_req_rdy),
    .mem_req_type    (mem_req_type),
    .mem_req_addr    (mem_req_addr),
    .mem_req_data    (mem_req_data),
    .resp_msg        (chain_msg[NUM_RESP_STAGES]),
    .resp_val        (chain_val[NUM_RESP_STAGES]),
    .resp_rdy        (chain_rdy[NUM_RESP_STAGES])
  );

  bram_port #(
    .RAM_AW          (RAM_AW),
    .NUM_RESP_STAGES (NUM_RESP_STAGES)
  ) u_bram (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .mem_req_val     (mem_req_val),
    .mem_req_rdy     (mem_req_rdy),
    .mem_req_type    (mem_req_type),
    .mem_req_addr    (mem_req_addr),
    .mem_req_data    (mem_req_data),
    .stage_full      (stage_full),
    .enq_msg         (chain_msg[0]),
    .enq_val         (chain_val[0]),
    .enq_rdy         (chain_rdy[0])
  );

  // stage k drains into stage k+1
  for (genvar k = 0; k < NUM_RESP_STAGES; k++) begin : g_resp_q
    bypass_queue_stage #(
      .MSG_W (RESP_MSG_W)
    ) u_stage (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .enq_msg         (chain_msg[k]),
      .enq_val         (chain_val[k]),
      .enq_rdy         (chain_rdy[k]),
      .deq_msg         (chain_msg[k+1]),
      .deq_val         (chain_val[k+1]),
      .deq_rdy         (chain_rdy[k+1]),
      .full            (stage_full[k])
    );
  end

endmodule

// File: bench/mbox_checker.sv
// mailbox response checker
// watches the host AXI-Lite port, keeps a model of the memory
// window and compares every b and r response against it
`timescale 1ns/1ps

module mbox_checker
  import mbox_pkg::*;
#(
  parameter int RAM_AW = 8
) (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  input  logic [MBOX_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  input  logic                   awready,
  input  logic [MBOX_DATA_W-1:0] wdata,
  input  logic                   wvalid,
  input  logic                   wready,
  input  logic [1:0]             bresp,
  input  logic                   bvalid,
  input  logic                   bready,
  input  logic [MBOX_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  input  logic                   arready,
  input  logic [MBOX_DATA_W-1:0] rdata,
  input  logic [1:0]             rresp,
  input  logic                   rvalid,
  input  logic                   rready,
  output int                     err_count,
  output int                     test_count,
  output int                     resp_count
);

  // window model with words unknown until written
  logic [MBOX_DATA_W-1:0] model [2**RAM_AW];
  logic                   model_ok [2**RAM_AW];
  logic [MBOX_ADDR_W-1:0] wr_addr_q, rd_addr_q;
  logic [MBOX_DATA_W-1:0] wr_data_q, rdata_q;
  logic [1:0]             bresp_q, rresp_q;
  logic                   wr_pend, rd_pend, rst_q, b_hold, r_hold;
  int                     err_mark;

  initial begin
    err_count  = 0;
    test_count = 0;
    resp_count = 0;
    err_mark   = 0;
  end

  function automatic logic in_window(input logic [MBOX_ADDR_W-1:0] addr);
    in_window = addr >= RAM_BASE_ADDR && (addr - RAM_BASE_ADDR) < (32'd4 << RAM_AW);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s: expected 0x%0h got 0x%0h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic close_test(input string what);
    test_count++;
    $display("test %0d: %s %s", test_count, what, (err_count == err_mark) ? "ok" : "FAILED");
    err_mark = err_count;
  endtask

  // --------------------------------------
  // completed transactions
  // --------------------------------------
  task automatic finish_write();
    int idx;
    idx = (wr_addr_q - RAM_BASE_ADDR) >> 2;
    if (!wr_pend) begin
      $display("write response arrived without an accepted write");
      err_count++;
    end
    check_value("bresp", in_window(wr_addr_q) ? RESP_OKAY : RESP_SLVERR, bresp);
    if (in_window(wr_addr_q)) begin
      model[idx]    = wr_data_q;
      model_ok[idx] = 1'b1;
    end
    wr_pend = 1'b0;
    resp_count++;
    close_test($sformatf("write 0x%08h <- 0x%08h", wr_addr_q, wr_data_q));
  endtask

  task automatic finish_read();
    int idx;
    idx = (rd_addr_q - RAM_BASE_ADDR) >> 2;
    if (!rd_pend) begin
      $display("read response arrived without an accepted read");
      err_count++;
    end
    if (in_window(rd_addr_q)) begin
      check_value("rresp", RESP_OKAY, rresp);
      if (model_ok[idx]) begin
        check_value("rdata", model[idx], rdata);
      end
    end else if (rd_addr_q == ID_REG_ADDR) begin
      check_value("rresp", RESP_OKAY, rresp);
      check_value("rdata", MBOX_ID, rdata);
    end else begin
      check_value("rresp", RESP_SLVERR, rresp);
      check_value("rdata", '0, rdata);
    end
    rd_pend = 1'b0;
    resp_count++;
    close_test($sformatf("read 0x%08h -> 0x%08h", rd_addr_q, rdata));
  endtask

  always @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rst_q   = 1'b0;
      wr_pend = 1'b0;
      rd_pend = 1'b0;
      b_hold  = 1'b0;
      r_hold  = 1'b0;
      for (int i = 0; i < 2**RAM_AW; i++) begin
        model_ok[i] = 1'b0;
      end
    end else begin
      // first edge out of reset
      if (!rst_q) begin
        check_value("bvalid", 1'b0, bvalid);
        check_value("rvalid", 1'b0, rvalid);
        check_value("awready", 1'b1, awready);
        check_value("arready", 1'b1, arready);
        close_test("reset state");
      end
      rst_q = 1'b1;
      // stalled responses must not move
      if (b_hold) begin
        check_value("bvalid", 1'b1, bvalid);
        check_value("bresp", bresp_q, bresp);
      end
      if (r_hold) begin
        check_value("rvalid", 1'b1, rvalid);
        check_value("rresp", rresp_q, rresp);
        check_value("rdata", rdata_q, rdata);
      end
      b_hold  = bvalid && !bready;
      r_hold  = rvalid && !rready;
      bresp_q = bresp;
      rresp_q = rresp;
      rdata_q = rdata;
      if (awvalid && awready) wr_addr_q = awaddr;
      if (wvalid && wready) begin
        wr_data_q = wdata;
        wr_pend   = 1'b1;
      end
      if (bvalid && bready) finish_write();
      if (arvalid && arready) begin
        rd_addr_q = araddr;
        rd_pend   = 1'b1;
      end
      if (rvalid && rready) finish_read();
    end
  end

endmodule

// File: bench/mbox_tb.sv
// mailbox testbench top
// clock, reset, stimulus file reader and AXI-Lite host driver,
// with the response checker instantiated beside the DUT
`timescale 1ns/1ps

module mbox_tb;
  import mbox_pkg::*;

  localparam int RAM_AW          = 8;
  localparam int NUM_RESP_STAGES = 2;
  localparam int CLK_PERIOD      = 40;
  localparam int MAX_OPS         = 64;
  localparam int WAIT_LIMIT      = 200;
  localparam logic [31:0] SEED   = 32'h3112_bc1a;
  // handshake selectors for wait_for
  localparam int HS_AW = 0;
  localparam int HS_W  = 1;
  localparam int HS_B  = 2;
  localparam int HS_AR = 3;
  localparam int HS_R  = 4;

  logic                   clk_main_a0;
  logic                   rst_main_n_sync;
  logic [MBOX_ADDR_W-1:0] awaddr, araddr;
  logic                   awvalid, awready, wvalid, wready;
  logic [MBOX_DATA_W-1:0] wdata, rdata;
  logic [1:0]             bresp, rresp;
  logic                   bvalid, bready, arvalid, arready, rvalid, rready;
  int                     err_count, test_count, resp_count;

  // four words per op of op code, byte address, write data and stall cycles
  logic [31:0] stim_mem [4*MAX_OPS];
  int          ops_issued;
  int          idx;
  logic        timed_out;
  logic        bad_stim;

  mbox_top #(
    .RAM_AW          (RAM_AW),
    .NUM_RESP_STAGES (NUM_RESP_STAGES)
  ) DUT (.*);

  mbox_checker #(
    .RAM_AW (RAM_AW)
  ) u_checker (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #(CLK_PERIOD/2) clk_main_a0 = ~clk_main_a0;
  end

  // sampled value of a ready or valid at the current edge
  function automatic logic port_high(input int which);
    case (which)
      HS_AW:   port_high = awready;
      HS_W:    port_high = wready;
      HS_B:    port_high = bvalid;
      HS_AR:   port_high = arready;
      default: port_high = rvalid;
    endcase
  endfunction

  task automatic wait_for(input int which, input string name);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && !timed_out && cycles < WAIT_LIMIT) begin
      @(posedge clk_main_a0);
      seen = port_high(which);
      cycles++;
    end
    if (!seen && !timed_out) begin
      $display("timeout: %s not seen within %0d cycles", name, cycles);
      timed_out = 1'b1;
    end
  endtask

  // --------------------------------------
  // host transactions
  // --------------------------------------
  task automatic host_write(input logic [31:0] addr, input logic [31:0] data, input int stall);
    @(negedge clk_main_a0);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    wait_for(HS_AW, "awready");
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wait_for(HS_W, "wready");
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    wait_for(HS_B, "bvalid");
    // host holds off the response for a while
    repeat (stall) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    bready = 1'b1;
    wait_for(HS_B, "bvalid with bready");
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  task automatic host_read(input logic [31:0] addr, input int stall);
    @(negedge clk_main_a0);
    araddr  = addr;
    arvalid = 1'b1;
    wait_for(HS_AR, "arready");
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    wait_for(HS_R, "rvalid");
    repeat (stall) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rready = 1'b1;
    wait_for(HS_R, "rvalid with rready");
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  // --------------------------------------
  // main sequence
  // --------------------------------------
  initial begin
    rst_main_n_sync = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    timed_out  = 1'b0;
    bad_stim   = 1'b0;
    ops_issued = 0;
    void'($urandom(SEED));
    $readmemh("bench/mbox_stim.txt", stim_mem);
    repeat (10) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    repeat (2) @(negedge clk_main_a0);
    idx = 0;
    // unfilled entries stay unknown and end the list
    while (idx < MAX_OPS && stim_mem[4*idx] !== 'x && !timed_out) begin
      if (stim_mem[4*idx] == 32'd1) begin
        host_write(stim_mem[4*idx+1], stim_mem[4*idx+2], stim_mem[4*idx+3]);
        ops_issued++;
      end else if (stim_mem[4*idx] == 32'd0) begin
        host_read(stim_mem[4*idx+1], stim_mem[4*idx+3]);
        ops_issued++;
      end else begin
        $display("unknown operation code %0h in stimulus entry %0d", stim_mem[4*idx], idx);
        bad_stim = 1'b1;
      end
      // short random idle gap between transactions
      repeat ($urandom_range(2, 0)) @(posedge clk_main_a0);
      idx++;
    end
    repeat (2) @(negedge clk_main_a0);
    if (ops_issued == 0) begin
      $display("no operations were read from the stimulus file");
      bad_stim = 1'b1;
    end
    if (resp_count != ops_issued) begin
      $display("response count %0d does not match %0d issued operations",
               resp_count, ops_issued);
    end
    $display("summary: %0d tests, %0d responses, %0d errors", test_count, resp_count,
             err_count);
    if (err_count == 0 && !timed_out && !bad_stim && resp_count == ops_issued) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: bench/mbox_stim.txt
// op (1 write, 0 read)  byte address  write data  stall cycles
// hex words, one operation per line
1 00001000 a5a50001 0
0 00001000 00000000 0
1 00001004 11110004 2
1 00001010 22220010 0
1 000013fc 333303fc 1
0 00001010 00000000 3
0 000013fc 00000000 0
0 00001004 00000000 1
1 00001004 4444beef 0
0 00001004 00000000 2
0 00000000 00000000 0
1 00000000 deadbeef 1
0 00000000 00000000 0
1 00001400 55555555 0
1 00000800 66666666 2
0 00001400 00000000 4
0 00001000 00000000 0

// File: files.f
common/mbox_pkg.sv
bram/bypass_queue_stage.sv
bram/bram_port.sv
host_if/axil_mbox_slave.sv
hdl/mbox_top.sv
bench/mbox_checker.sv
bench/mbox_tb.sv
